// File: idu_config.svh
// Decode unit widths, register numbers and opcode values
`ifndef IDU_CONFIG_SVH
`define IDU_CONFIG_SVH

// Datapath and address widths, PC is a word address of IDU_AW-2 bits
`define IDU_DW          32
`define IDU_AW          32
`define IDU_REG_AW      5
`define IDU_REGNO_LNK   1

// One-hot operation bus widths
`define IDU_ALU_OPW     17
`define IDU_EPU_OPW     6

// Opcode map, 0 and everything above 36 are unassigned
`define IDU_OP_AND        7'd1
`define IDU_OP_AND_I      7'd2
`define IDU_OP_OR         7'd3
`define IDU_OP_OR_I       7'd4
`define IDU_OP_XOR        7'd5
`define IDU_OP_XOR_I      7'd6
`define IDU_OP_LSL        7'd7
`define IDU_OP_LSL_I      7'd8
`define IDU_OP_LSR        7'd9
`define IDU_OP_LSR_I      7'd10
`define IDU_OP_ASR        7'd11
`define IDU_OP_ASR_I      7'd12
`define IDU_OP_ADD        7'd13
`define IDU_OP_ADD_I      7'd14
`define IDU_OP_SUB        7'd15
`define IDU_OP_MHI        7'd16
`define IDU_OP_JMP_I      7'd17
`define IDU_OP_JMP_LNK_I  7'd18
`define IDU_OP_JMP        7'd19
`define IDU_OP_BEQ        7'd20
`define IDU_OP_BNE        7'd21
`define IDU_OP_BLT        7'd22
`define IDU_OP_BLTU       7'd23
`define IDU_OP_BGE        7'd24
`define IDU_OP_BGEU       7'd25
`define IDU_OP_LDB        7'd26
`define IDU_OP_LDBU       7'd27
`define IDU_OP_LDH        7'd28
`define IDU_OP_LDHU       7'd29
`define IDU_OP_LDWU       7'd30
`define IDU_OP_STB        7'd31
`define IDU_OP_STH        7'd32
`define IDU_OP_STW        7'd33
`define IDU_OP_MBARR      7'd34
`define IDU_OP_SYSCALL    7'd35
`define IDU_OP_RET        7'd36

`endif

// File: idu_isa_pkg.sv
// Instruction encoding types of the decode unit
`default_nettype none
`include "idu_config.svh"

package idu_isa_pkg;

   typedef logic [6:0]              opcode_t;
   typedef logic [`IDU_REG_AW-1:0]  reg_addr_t;
   typedef logic [`IDU_AW-3:0]      pc_t;
   typedef logic [`IDU_DW-1:0]      insn_t;

   // Fetch exception flags
   typedef logic [2:0]              exc_t;
   localparam int EXC_ITLB = 0;
   localparam int EXC_IPF  = 1;
   localparam int EXC_IRQ  = 2;

   // Immediate fields as they sit in the instruction word
   typedef logic [14:0]             imm15_t;
   typedef logic [16:0]             imm17_t;
   typedef logic [24:0]             rel25_t;

endpackage

`default_nettype wire

// File: idu_uop_pkg.sv
// Decoded micro-operation types of the decode unit
`default_nettype none
`include "idu_config.svh"

package idu_uop_pkg;

   // ALU operation bus, one bit per operation
   typedef logic [`IDU_ALU_OPW-1:0] alu_opc_t;
   localparam int ALU_AND    = 0;
   localparam int ALU_OR     = 1;
   localparam int ALU_XOR    = 2;
   localparam int ALU_LSL    = 3;
   localparam int ALU_LSR    = 4;
   localparam int ALU_ASR    = 5;
   localparam int ALU_ADD    = 6;
   localparam int ALU_SUB    = 7;
   localparam int ALU_MHI    = 8;
   localparam int ALU_BEQ    = 9;
   localparam int ALU_BNE    = 10;
   localparam int ALU_BLT    = 11;
   localparam int ALU_BLTU   = 12;
   localparam int ALU_BGE    = 13;
   localparam int ALU_BGEU   = 14;
   localparam int ALU_JMPREL = 15;
   localparam int ALU_JMPREG = 16;

   // Exception unit bus, EINSN marks an instruction to be emulated
   typedef logic [`IDU_EPU_OPW-1:0] epu_opc_t;
   localparam int EPU_ESYSCALL = 0;
   localparam int EPU_ERET     = 1;
   localparam int EPU_EITM     = 2;
   localparam int EPU_EIPF     = 3;
   localparam int EPU_EIRQ     = 4;
   localparam int EPU_EINSN    = 5;

   typedef enum logic [2:0] {
      MEM_NONE = 3'd0,
      MEM_BYTE = 3'd1,
      MEM_HALF = 3'd2,
      MEM_WORD = 3'd3
   } mem_size_e;

   typedef enum logic [2:0] {
      IMM_NONE,
      IMM_SIMM15,
      IMM_UIMM15,
      IMM_UIMM17,
      IMM_REL25
   } imm_kind_e;

   typedef logic [`IDU_DW-1:0] data_t;

endpackage

`default_nettype wire

// File: idu_classify_stage.sv
// First decode stage, matches the opcode and registers the operation class
`timescale 1ns/1ps
`default_nettype none
`include "idu_config.svh"

module idu_classify_stage
(
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   flush_i,
   input  logic                   valid_i,
   input  idu_isa_pkg::insn_t     insn_i,
   input  idu_isa_pkg::pc_t       pc_i,
   input  idu_isa_pkg::exc_t      exc_i,
   input  logic                   ready_i,
   output logic                   ready_o,
   output logic                   valid_o,
   output idu_isa_pkg::pc_t       pc_o,
   output idu_uop_pkg::alu_opc_t  alu_opc_o,
   output idu_uop_pkg::epu_opc_t  epu_opc_o,
   output idu_uop_pkg::mem_size_e load_size_o,
   output idu_uop_pkg::mem_size_e store_size_o,
   output logic                   sign_ext_o,
   output logic                   barr_o,
   output idu_isa_pkg::reg_addr_t rs1_addr_o,
   output idu_isa_pkg::reg_addr_t rs2_addr_o,
   output idu_isa_pkg::reg_addr_t rd_addr_o,
   output idu_isa_pkg::imm15_t    imm15_o,
   output idu_isa_pkg::imm17_t    imm17_o,
   output idu_isa_pkg::rel25_t    rel25_o,
   output idu_uop_pkg::imm_kind_e imm_kind_o,
   output logic                   no_rops_o,
   output logic                   rd_as_rs2_o,
   output logic                   not_wb_o
);

   import idu_isa_pkg::*;
   import idu_uop_pkg::*;

   opcode_t   opcode;
   alu_opc_t  alu_opc;
   epu_opc_t  epu_opc;
   mem_size_e load_size;
   mem_size_e store_size;
   imm_kind_e imm_kind;
   logic      barr;
   logic      sign_ext;
   logic      op_syscall;
   logic      op_ret;
   logic      op_jmp_i;
   logic      op_jmp_lnk_i;
   logic      is_load;
   logic      is_store;
   logic      is_bcc;
   logic      is_simm15;
   logic      is_uimm15;
   logic      load;

   // A faulting fetch decodes as opcode 0 so only its EPU bits survive
   assign opcode = (|exc_i) ? '0 : insn_i[6:0];

   always_comb
   begin
      alu_opc = '0;
      load_size = MEM_NONE;
      store_size = MEM_NONE;
      barr = 1'b0;
      op_syscall = 1'b0;
      op_ret = 1'b0;
      case (opcode)
         `IDU_OP_AND, `IDU_OP_AND_I:     alu_opc[ALU_AND] = 1'b1;
         `IDU_OP_OR, `IDU_OP_OR_I:       alu_opc[ALU_OR] = 1'b1;
         `IDU_OP_XOR, `IDU_OP_XOR_I:     alu_opc[ALU_XOR] = 1'b1;
         `IDU_OP_LSL, `IDU_OP_LSL_I:     alu_opc[ALU_LSL] = 1'b1;
         `IDU_OP_LSR, `IDU_OP_LSR_I:     alu_opc[ALU_LSR] = 1'b1;
         `IDU_OP_ASR, `IDU_OP_ASR_I:     alu_opc[ALU_ASR] = 1'b1;
         `IDU_OP_ADD, `IDU_OP_ADD_I:     alu_opc[ALU_ADD] = 1'b1;
         `IDU_OP_SUB:                    alu_opc[ALU_SUB] = 1'b1;
         `IDU_OP_MHI:                    alu_opc[ALU_MHI] = 1'b1;
         `IDU_OP_JMP_I, `IDU_OP_JMP_LNK_I: alu_opc[ALU_JMPREL] = 1'b1;
         `IDU_OP_JMP:                    alu_opc[ALU_JMPREG] = 1'b1;
         `IDU_OP_BEQ:                    alu_opc[ALU_BEQ] = 1'b1;
         `IDU_OP_BNE:                    alu_opc[ALU_BNE] = 1'b1;
         `IDU_OP_BLT:                    alu_opc[ALU_BLT] = 1'b1;
         `IDU_OP_BLTU:                   alu_opc[ALU_BLTU] = 1'b1;
         `IDU_OP_BGE:                    alu_opc[ALU_BGE] = 1'b1;
         `IDU_OP_BGEU:                   alu_opc[ALU_BGEU] = 1'b1;
         `IDU_OP_LDB, `IDU_OP_LDBU:      load_size = MEM_BYTE;
         `IDU_OP_LDH, `IDU_OP_LDHU:      load_size = MEM_HALF;
         `IDU_OP_LDWU:                   load_size = MEM_WORD;
         `IDU_OP_STB:                    store_size = MEM_BYTE;
         `IDU_OP_STH:                    store_size = MEM_HALF;
         `IDU_OP_STW:                    store_size = MEM_WORD;
         `IDU_OP_MBARR:                  barr = 1'b1;
         `IDU_OP_SYSCALL:                op_syscall = 1'b1;
         `IDU_OP_RET:                    op_ret = 1'b1;
         default:                        ;
      endcase
   end

   assign sign_ext = (opcode == `IDU_OP_LDB) || (opcode == `IDU_OP_LDH);
   assign op_jmp_i = (opcode == `IDU_OP_JMP_I);
   assign op_jmp_lnk_i = (opcode == `IDU_OP_JMP_LNK_I);
   assign is_load = (load_size != MEM_NONE);
   assign is_store = (store_size != MEM_NONE);
   assign is_bcc = |alu_opc[ALU_BGEU:ALU_BEQ];

   // Loads and stores take a signed offset
   assign is_simm15 = (opcode inside {`IDU_OP_XOR_I, `IDU_OP_ADD_I}) | is_load | is_store;
   assign is_uimm15 = opcode inside {`IDU_OP_AND_I, `IDU_OP_OR_I, `IDU_OP_LSL_I,
                                     `IDU_OP_LSR_I, `IDU_OP_ASR_I};
   assign imm_kind = is_simm15 ? IMM_SIMM15 :
                     is_uimm15 ? IMM_UIMM15 :
                     alu_opc[ALU_MHI] ? IMM_UIMM17 :
                     alu_opc[ALU_JMPREL] ? IMM_REL25 : IMM_NONE;

   always_comb
   begin
      epu_opc = '0;
      epu_opc[EPU_ESYSCALL] = op_syscall;
      epu_opc[EPU_ERET] = op_ret;
      epu_opc[EPU_EITM] = exc_i[EXC_ITLB];
      epu_opc[EPU_EIPF] = exc_i[EXC_IPF];
      epu_opc[EPU_EIRQ] = exc_i[EXC_IRQ];
      // Nothing else claimed it, so the instruction is emulated
      epu_opc[EPU_EINSN] = ~((|alu_opc) | is_load | is_store | barr | (|epu_opc));
   end

   assign ready_o = ~flush_i & (~valid_o | ready_i);
   assign load = valid_i & ready_o;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_o <= 1'b0;
         alu_opc_o <= '0;
         epu_opc_o <= '0;
         load_size_o <= MEM_NONE;
         store_size_o <= MEM_NONE;
         sign_ext_o <= 1'b0;
         barr_o <= 1'b0;
      end
      else
      begin
         if (flush_i)
            valid_o <= 1'b0;
         else if (ready_o)
            valid_o <= valid_i;
         if (load)
         begin
            alu_opc_o <= alu_opc;
            epu_opc_o <= epu_opc;
            load_size_o <= load_size;
            store_size_o <= store_size;
            sign_ext_o <= sign_ext;
            barr_o <= barr;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         pc_o <= pc_i;
         rs1_addr_o <= insn_i[16:12];
         rs2_addr_o <= insn_i[21:17];
         rd_addr_o <= op_jmp_lnk_i ? reg_addr_t'(`IDU_REGNO_LNK) : insn_i[11:7];
         imm15_o <= insn_i[31:17];
         imm17_o <= insn_i[28:12];
         rel25_o <= insn_i[31:7];
         imm_kind_o <= imm_kind;
         no_rops_o <= alu_opc[ALU_MHI] | alu_opc[ALU_JMPREL] | barr | op_syscall | op_ret;
         rd_as_rs2_o <= is_store | is_bcc;
         not_wb_o <= op_jmp_i | is_bcc | is_store | barr | (|epu_opc);
      end
   end

   // Opcode groups must never overlap on the ALU bus
   a_alu_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_o |-> $onehot0(alu_opc_o));

endmodule

`default_nettype wire

// File: idu_operand_stage.sv
// Second decode stage, register reads, immediate and writeback request
`timescale 1ns/1ps
`default_nettype none
`include "idu_config.svh"

module idu_operand_stage
(
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   flush_i,
   input  logic                   valid_i,
   input  idu_isa_pkg::pc_t       pc_i,
   input  idu_uop_pkg::alu_opc_t  alu_opc_i,
   input  idu_uop_pkg::epu_opc_t  epu_opc_i,
   input  idu_uop_pkg::mem_size_e load_size_i,
   input  idu_uop_pkg::mem_size_e store_size_i,
   input  logic                   sign_ext_i,
   input  logic                   barr_i,
   input  idu_isa_pkg::reg_addr_t rs1_addr_i,
   input  idu_isa_pkg::reg_addr_t rs2_addr_i,
   input  idu_isa_pkg::reg_addr_t rd_addr_i,
   input  idu_isa_pkg::imm15_t    imm15_i,
   input  idu_isa_pkg::imm17_t    imm17_i,
   input  idu_isa_pkg::rel25_t    rel25_i,
   input  idu_uop_pkg::imm_kind_e imm_kind_i,
   input  logic                   no_rops_i,
   input  logic                   rd_as_rs2_i,
   input  logic                   not_wb_i,
   input  logic                   ready_i,
   output logic                   ready_o,
   output logic                   valid_o,
   output idu_isa_pkg::pc_t       pc_o,
   output idu_uop_pkg::alu_opc_t  alu_opc_o,
   output idu_uop_pkg::epu_opc_t  epu_opc_o,
   output idu_uop_pkg::mem_size_e load_size_o,
   output idu_uop_pkg::mem_size_e store_size_o,
   output logic                   sign_ext_o,
   output logic                   barr_o,
   output logic                   rs1_re_o,
   output idu_isa_pkg::reg_addr_t rs1_addr_o,
   output logic                   rs2_re_o,
   output idu_isa_pkg::reg_addr_t rs2_addr_o,
   output idu_uop_pkg::data_t     imm_o,
   output logic                   rd_we_o,
   output idu_isa_pkg::reg_addr_t rd_addr_o
);

   import idu_uop_pkg::*;

   data_t imm;
   logic  load;

   always_comb
   begin
      case (imm_kind_i)
         IMM_SIMM15: imm = {{(`IDU_DW-15){imm15_i[14]}}, imm15_i};
         IMM_UIMM15: imm = {{(`IDU_DW-15){1'b0}}, imm15_i};
         IMM_UIMM17: imm = {{(`IDU_DW-17){1'b0}}, imm17_i};
         // Word offset turned into a byte offset
         IMM_REL25:  imm = {{(`IDU_DW-27){rel25_i[24]}}, rel25_i, 2'b00};
         default:    imm = '0;
      endcase
   end

   assign ready_o = ~flush_i & (~valid_o | ready_i);
   assign load = valid_i & ready_o;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_o <= 1'b0;
         alu_opc_o <= '0;
         epu_opc_o <= '0;
         load_size_o <= MEM_NONE;
         store_size_o <= MEM_NONE;
         sign_ext_o <= 1'b0;
         barr_o <= 1'b0;
         rs1_re_o <= 1'b0;
         rs2_re_o <= 1'b0;
         rd_we_o <= 1'b0;
      end
      else
      begin
         if (flush_i)
            valid_o <= 1'b0;
         else if (ready_o)
            valid_o <= valid_i;
         if (load)
         begin
            alu_opc_o <= alu_opc_i;
            epu_opc_o <= epu_opc_i;
            load_size_o <= load_size_i;
            store_size_o <= store_size_i;
            sign_ext_o <= sign_ext_i;
            barr_o <= barr_i;
            rs1_re_o <= ~no_rops_i;
            // Stores and branches compare or store the rd register
            rs2_re_o <= rd_as_rs2_i | ((imm_kind_i == IMM_NONE) & ~no_rops_i);
            // r0 is hardwired, never written
            rd_we_o <= ~not_wb_i & (|rd_addr_i);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         pc_o <= pc_i;
         rs1_addr_o <= rs1_addr_i;
         rs2_addr_o <= rd_as_rs2_i ? rd_addr_i : rs2_addr_i;
         imm_o <= imm;
         rd_addr_o <= rd_addr_i;
      end
   end

   // A stalled output word may not change until the consumer takes it
   a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      (valid_o && !ready_i && !flush_i) |=> valid_o &&
      $stable({pc_o, alu_opc_o, epu_opc_o, load_size_o, store_size_o, sign_ext_o, barr_o,
               rs1_re_o, rs1_addr_o, rs2_re_o, rs2_addr_o, imm_o, rd_we_o, rd_addr_o}));

endmodule

`default_nettype wire

// File: idu_top.sv
// Instruction decode unit, classify stage followed by operand stage
`timescale 1ns/1ps
`default_nettype none

module idu_top
(
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   flush_i,
   input  logic                   valid_i,
   input  idu_isa_pkg::insn_t     insn_i,
   input  idu_isa_pkg::pc_t       pc_i,
   input  idu_isa_pkg::exc_t      exc_i,
   input  logic                   ready_i,
   output logic                   ready_o,
   output logic                   valid_o,
   output idu_isa_pkg::pc_t       pc_o,
   output idu_uop_pkg::alu_opc_t  alu_opc_o,
   output idu_uop_pkg::epu_opc_t  epu_opc_o,
   output idu_uop_pkg::mem_size_e load_size_o,
   output idu_uop_pkg::mem_size_e store_size_o,
   output logic                   sign_ext_o,
   output logic                   barr_o,
   output logic                   rs1_re_o,
   output idu_isa_pkg::reg_addr_t rs1_addr_o,
   output logic                   rs2_re_o,
   output idu_isa_pkg::reg_addr_t rs2_addr_o,
   output idu_uop_pkg::data_t     imm_o,
   output logic                   rd_we_o,
   output idu_isa_pkg::reg_addr_t rd_addr_o
);

   import idu_isa_pkg::*;
   import idu_uop_pkg::*;

   // Class payload between the two stages
   logic      cls_valid;
   logic      cls_ready;
   pc_t       cls_pc;
   alu_opc_t  cls_alu_opc;
   epu_opc_t  cls_epu_opc;
   mem_size_e cls_load_size;
   mem_size_e cls_store_size;
   logic      cls_sign_ext;
   logic      cls_barr;
   reg_addr_t cls_rs1_addr;
   reg_addr_t cls_rs2_addr;
   reg_addr_t cls_rd_addr;
   imm15_t    cls_imm15;
   imm17_t    cls_imm17;
   rel25_t    cls_rel25;
   imm_kind_e cls_imm_kind;
   logic      cls_no_rops;
   logic      cls_rd_as_rs2;
   logic      cls_not_wb;

   idu_classify_stage u_classify
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .flush_i      (flush_i),
      .valid_i      (valid_i),
      .insn_i       (insn_i),
      .pc_i         (pc_i),
      .exc_i        (exc_i),
      .ready_i      (cls_ready),
      .ready_o      (ready_o),
      .valid_o      (cls_valid),
      .pc_o         (cls_pc),
      .alu_opc_o    (cls_alu_opc),
      .epu_opc_o    (cls_epu_opc),
      .load_size_o  (cls_load_size),
      .store_size_o (cls_store_size),
      .sign_ext_o   (cls_sign_ext),
      .barr_o       (cls_barr),
      .rs1_addr_o   (cls_rs1_addr),
      .rs2_addr_o   (cls_rs2_addr),
      .rd_addr_o    (cls_rd_addr),
      .imm15_o      (cls_imm15),
      .imm17_o      (cls_imm17),
      .rel25_o      (cls_rel25),
      .imm_kind_o   (cls_imm_kind),
      .no_rops_o    (cls_no_rops),
      .rd_as_rs2_o  (cls_rd_as_rs2),
      .not_wb_o     (cls_not_wb)
   );

   idu_operand_stage u_operand
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .flush_i      (flush_i),
      .valid_i      (cls_valid),
      .pc_i         (cls_pc),
      .alu_opc_i    (cls_alu_opc),
      .epu_opc_i    (cls_epu_opc),
      .load_size_i  (cls_load_size),
      .store_size_i (cls_store_size),
      .sign_ext_i   (cls_sign_ext),
      .barr_i       (cls_barr),
      .rs1_addr_i   (cls_rs1_addr),
      .rs2_addr_i   (cls_rs2_addr),
      .rd_addr_i    (cls_rd_addr),
      .imm15_i      (cls_imm15),
      .imm17_i      (cls_imm17),
      .rel25_i      (cls_rel25),
      .imm_kind_i   (cls_imm_kind),
      .no_rops_i    (cls_no_rops),
      .rd_as_rs2_i  (cls_rd_as_rs2),
      .not_wb_i     (cls_not_wb),
      .ready_i      (ready_i),
      .ready_o      (cls_ready),
      .valid_o      (valid_o),
      .pc_o         (pc_o),
      .alu_opc_o    (alu_opc_o),
      .epu_opc_o    (epu_opc_o),
      .load_size_o  (load_size_o),
      .store_size_o (store_size_o),
      .sign_ext_o   (sign_ext_o),
      .barr_o       (barr_o),
      .rs1_re_o     (rs1_re_o),
      .rs1_addr_o   (rs1_addr_o),
      .rs2_re_o     (rs2_re_o),
      .rs2_addr_o   (rs2_addr_o),
      .imm_o        (imm_o),
      .rd_we_o      (rd_we_o),
      .rd_addr_o    (rd_addr_o)
   );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// Testbench clock and reset source, 10 ns clock and a 3 cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
   output logic clk_o,
   output logic arst_n_o
);

   localparam int HALF_PERIOD = 5;
   localparam int RESET_CYCLES = 3;

   initial
   begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Release away from the rising edge
   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb_idu.sv
// Decode unit testbench with reference model, scoreboard queue and checkers
`timescale 1ns/1ps
`default_nettype none
`include "idu_config.svh"

module tb_idu;

   import idu_isa_pkg::*;
   import idu_uop_pkg::*;

   localparam int N_SWEEP = 164;
   localparam int N_EXC = 120;
   localparam int N_RAND = 600;
   localparam int WATCHDOG_CYCLES = (N_SWEEP + N_EXC + N_RAND) * 4 + 50;

   // One expected output word
   typedef struct packed {
      pc_t       pc;
      alu_opc_t  alu;
      epu_opc_t  epu;
      mem_size_e load_size;
      mem_size_e store_size;
      logic      sign_ext;
      logic      barr;
      logic      rs1_re;
      reg_addr_t rs1;
      logic      rs2_re;
      reg_addr_t rs2;
      data_t     imm;
      logic      rd_we;
      reg_addr_t rd;
   } exp_t;

   logic      clk;
   logic      arst_n;
   logic      flush;
   logic      in_valid;
   logic      in_ready;
   insn_t     insn;
   pc_t       pc;
   exc_t      exc;
   logic      out_ready;
   logic      out_valid;
   pc_t       out_pc;
   alu_opc_t  out_alu;
   epu_opc_t  out_epu;
   mem_size_e out_load_size;
   mem_size_e out_store_size;
   logic      out_sign_ext;
   logic      out_barr;
   logic      out_rs1_re;
   reg_addr_t out_rs1;
   logic      out_rs2_re;
   reg_addr_t out_rs2;
   data_t     out_imm;
   logic      out_rd_we;
   reg_addr_t out_rd;
   exp_t      out_word;
   logic      xfer;

   exp_t        exp_q[$];
   exp_t        exp_head;
   logic        exp_valid = 1'b0;
   logic [31:0] lfsr = 32'hdb0f;
   pc_t         next_pc = '0;
   int          errors = 0;
   int          checks = 0;

   tb_clk_gen u_clk_gen
   (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   idu_top DUT
   (
      .clk          (clk),
      .arst_n_i     (arst_n),
      .flush_i      (flush),
      .valid_i      (in_valid),
      .insn_i       (insn),
      .pc_i         (pc),
      .exc_i        (exc),
      .ready_i      (out_ready),
      .ready_o      (in_ready),
      .valid_o      (out_valid),
      .pc_o         (out_pc),
      .alu_opc_o    (out_alu),
      .epu_opc_o    (out_epu),
      .load_size_o  (out_load_size),
      .store_size_o (out_store_size),
      .sign_ext_o   (out_sign_ext),
      .barr_o       (out_barr),
      .rs1_re_o     (out_rs1_re),
      .rs1_addr_o   (out_rs1),
      .rs2_re_o     (out_rs2_re),
      .rs2_addr_o   (out_rs2),
      .imm_o        (out_imm),
      .rd_we_o      (out_rd_we),
      .rd_addr_o    (out_rd)
   );

   assign out_word = {out_pc, out_alu, out_epu, out_load_size, out_store_size, out_sign_ext,
                      out_barr, out_rs1_re, out_rs1, out_rs2_re, out_rs2, out_imm, out_rd_we,
                      out_rd};
   assign xfer = out_valid && out_ready && !flush;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // Takes n bits, one LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return r;
   endfunction

   function automatic exp_t expect_uop(input insn_t word, input pc_t addr, input exc_t fault);
      exp_t      e;
      opcode_t   op;
      int        opn;
      int        alu_bit;
      imm_kind_e kind;
      logic      is_branch;
      logic      no_rops;
      logic      rd_as_rs2;
      logic      not_wb;
      reg_addr_t rd;
      op = (fault != 3'd0) ? 7'd0 : word[6:0];
      opn = int'(op);
      is_branch = (op >= `IDU_OP_BEQ) && (op <= `IDU_OP_BGEU);
      e = '0;
      e.pc = addr;
      alu_bit = -1;
      // Register and immediate forms share a bus bit, in pairs from AND to SUB
      if (opn >= 1 && opn <= 15)
         alu_bit = (opn - 1) / 2;
      else if (op == `IDU_OP_MHI)
         alu_bit = ALU_MHI;
      else if (op == `IDU_OP_JMP_I || op == `IDU_OP_JMP_LNK_I)
         alu_bit = ALU_JMPREL;
      else if (op == `IDU_OP_JMP)
         alu_bit = ALU_JMPREG;
      else if (is_branch)
         alu_bit = ALU_BEQ + opn - int'(`IDU_OP_BEQ);
      if (alu_bit >= 0)
         e.alu = alu_opc_t'(1) << alu_bit;
      if (op == `IDU_OP_LDB || op == `IDU_OP_LDBU)
         e.load_size = MEM_BYTE;
      if (op == `IDU_OP_LDH || op == `IDU_OP_LDHU)
         e.load_size = MEM_HALF;
      if (op == `IDU_OP_LDWU)
         e.load_size = MEM_WORD;
      if (op == `IDU_OP_STB)
         e.store_size = MEM_BYTE;
      if (op == `IDU_OP_STH)
         e.store_size = MEM_HALF;
      if (op == `IDU_OP_STW)
         e.store_size = MEM_WORD;
      e.sign_ext = (op == `IDU_OP_LDB) || (op == `IDU_OP_LDH);
      e.barr = (op == `IDU_OP_MBARR);
      e.epu = {1'b0, fault, op == `IDU_OP_RET, op == `IDU_OP_SYSCALL};
      if (e.alu == '0 && e.load_size == MEM_NONE && e.store_size == MEM_NONE && !e.barr &&
          e.epu == '0)
         e.epu[EPU_EINSN] = 1'b1;
      if (op == `IDU_OP_XOR_I || op == `IDU_OP_ADD_I || e.load_size != MEM_NONE ||
          e.store_size != MEM_NONE)
         kind = IMM_SIMM15;
      else if (opn >= 2 && opn <= 12 && opn % 2 == 0)
         kind = IMM_UIMM15;
      else if (op == `IDU_OP_MHI)
         kind = IMM_UIMM17;
      else if (op == `IDU_OP_JMP_I || op == `IDU_OP_JMP_LNK_I)
         kind = IMM_REL25;
      else
         kind = IMM_NONE;
      no_rops = (op == `IDU_OP_MHI) || (op == `IDU_OP_MBARR) || (op == `IDU_OP_SYSCALL) ||
                (op == `IDU_OP_RET) || (op == `IDU_OP_JMP_I) || (op == `IDU_OP_JMP_LNK_I);
      rd_as_rs2 = (e.store_size != MEM_NONE) || is_branch;
      not_wb = (op == `IDU_OP_JMP_I) || is_branch || (e.store_size != MEM_NONE) || e.barr ||
               (e.epu != '0);
      rd = (op == `IDU_OP_JMP_LNK_I) ? reg_addr_t'(`IDU_REGNO_LNK) : word[11:7];
      e.rs1_re = !no_rops;
      e.rs1 = word[16:12];
      e.rs2_re = rd_as_rs2 || (kind == IMM_NONE && !no_rops);
      e.rs2 = rd_as_rs2 ? word[11:7] : word[21:17];
      case (kind)
         IMM_SIMM15: e.imm = {{17{word[31]}}, word[31:17]};
         IMM_UIMM15: e.imm = {17'd0, word[31:17]};
         IMM_UIMM17: e.imm = {15'd0, word[28:12]};
         IMM_REL25:  e.imm = {{5{word[31]}}, word[31:7], 2'b00};
         default:    e.imm = '0;
      endcase
      e.rd_we = !not_wb && (rd != '0);
      e.rd = rd;
      return e;
   endfunction

   // Mode 0 sweeps opcodes, mode 1 adds fetch faults, mode 2 is fully random
   task automatic offer_insn(input int mode, input int idx);
      logic [31:0] word;
      logic [31:0] sel;
      logic [31:0] r;
      exc_t        fault;
      word = rand_bits(32);
      if (mode == 0)
         sel = idx % 41;
      else
         sel = rand_bits(6) % 41;
      word[6:0] = sel[6:0];
      // First sweep pass targets r0
      if (mode == 0 && idx < 41)
         word[11:7] = '0;
      fault = '0;
      if (mode == 1 || (mode == 2 && rand_bits(3) == 0))
      begin
         r = rand_bits(3);
         fault = r[2:0];
      end
      insn <= word;
      exc <= fault;
      pc <= next_pc;
      next_pc = next_pc + pc_t'(1);
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - err_before);
   endtask

   task automatic run_test(input string name, input int n_insn, input int mode);
      int   accepted;
      int   made;
      int   err_before;
      logic pending;
      accepted = 0;
      made = 0;
      err_before = errors;
      pending = 1'b0;
      while (accepted < n_insn)
      begin
         @(posedge clk);
         if (in_valid && in_ready)
         begin
            pending = 1'b0;
            accepted++;
         end
         if (!pending && made < n_insn && (mode == 0 || rand_bits(2) != 0))
         begin
            offer_insn(mode, made);
            made++;
            pending = 1'b1;
         end
         in_valid <= pending;
         out_ready <= (mode == 0) || (rand_bits(mode == 1 ? 2 : 1) != 0);
         flush <= (mode == 2) && (rand_bits(4) == 0);
      end
      out_ready <= 1'b1;
      flush <= 1'b0;
      @(negedge clk);
      while (exp_q.size() != 0 || out_valid)
         @(negedge clk);
      report_test(name, err_before);
   endtask

   // Scoreboard, one queue entry per accepted instruction
   always @(posedge clk)
   begin
      if (flush)
         exp_q.delete();
      else
      begin
         if (out_valid && out_ready)
         begin
            if (exp_q.size() != 0)
               void'(exp_q.pop_front());
            checks++;
         end
         if (in_valid && in_ready)
            exp_q.push_back(expect_uop(insn, pc, exc));
      end
      exp_valid <= (exp_q.size() != 0);
      if (exp_q.size() != 0)
         exp_head <= exp_q[0];
   end

   a_order: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> exp_valid && out_pc == exp_head.pc)
      else
      begin
         $display("[FAIL] %0t: output pc %h is not the next expected one", $time,
                  $sampled(out_pc));
         errors++;
      end

   a_ops: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> out_alu == exp_head.alu && out_epu == exp_head.epu)
      else
      begin
         $display("[FAIL] %0t: ALU or EPU bus wrong for pc %h", $time, $sampled(out_pc));
         errors++;
      end

   a_mem: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> out_load_size == exp_head.load_size && out_store_size == exp_head.store_size &&
               out_sign_ext == exp_head.sign_ext && out_barr == exp_head.barr)
      else
      begin
         $display("[FAIL] %0t: memory access fields wrong for pc %h", $time, $sampled(out_pc));
         errors++;
      end

   a_regs: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> out_rs1_re == exp_head.rs1_re && (!exp_head.rs1_re || out_rs1 == exp_head.rs1) &&
               out_rs2_re == exp_head.rs2_re && (!exp_head.rs2_re || out_rs2 == exp_head.rs2))
      else
      begin
         $display("[FAIL] %0t: register read request wrong for pc %h", $time, $sampled(out_pc));
         errors++;
      end

   a_imm: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> out_imm == exp_head.imm)
      else
      begin
         $display("[FAIL] %0t: immediate %h wrong for pc %h", $time, $sampled(out_imm),
                  $sampled(out_pc));
         errors++;
      end

   a_wb: assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> out_rd_we == exp_head.rd_we && (!exp_head.rd_we || out_rd == exp_head.rd))
      else
      begin
         $display("[FAIL] %0t: writeback request wrong for pc %h", $time, $sampled(out_pc));
         errors++;
      end

   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && !out_ready && !flush) |=> out_valid && $stable(out_word))
      else
      begin
         $display("[FAIL] %0t: output changed while stalled", $time);
         errors++;
      end

   a_flush_block: assert property (@(posedge clk) disable iff (!arst_n)
      flush |-> !in_ready)
      else
      begin
         $display("[FAIL] %0t: input accepted during a flush", $time);
         errors++;
      end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout, the decode unit stopped delivering instructions");
      $display("sim failed");
      $finish;
   end

   initial
   begin
      flush = 1'b0;
      in_valid = 1'b0;
      insn = '0;
      pc = '0;
      exc = '0;
      out_ready = 1'b0;
      wait (arst_n);
      a_reset: assert (!out_valid && out_alu == '0 && out_epu == '0 && !out_barr &&
                       out_load_size == MEM_NONE && out_store_size == MEM_NONE &&
                       !out_sign_ext && !out_rs1_re && !out_rs2_re && !out_rd_we)
      else
      begin
         $display("[FAIL] %0t: outputs not cleared by reset", $time);
         errors++;
      end
      report_test("reset", 0);
      run_test("opcodes", N_SWEEP, 0);
      run_test("exceptions", N_EXC, 1);
      run_test("random", N_RAND, 2);
      $display("tests 4, transfers checked %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
idu_isa_pkg.sv
idu_uop_pkg.sv
idu_classify_stage.sv
idu_operand_stage.sv
idu_top.sv
tb_clk_gen.sv
tb_idu.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_idu
RTL_TOP   := idu_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
